/* src/amber_pkg.sv */
`default_nettype none

package amber_pkg;

    // Bus widths
    localparam int WB_DWIDTH = 32;
    localparam int WB_SWIDTH = 4;
    localparam int WB_AWIDTH = 32;

    // ------------------------------
    // Address map
    // ------------------------------
    localparam int SLAVE_SEL_HI = 31;
    localparam int SLAVE_SEL_LO = 24;

    localparam logic [7:0] BOOT_MEM_BASE = 8'h00;
    localparam logic [7:0] TIMER_BASE    = 8'h13;
    localparam logic [7:0] IC_BASE       = 8'h14;

    // Boot memory, 8 KB of 32 bit words
    localparam int BOOT_MEM_WORDS  = 2048;
    localparam int BOOT_MEM_AWIDTH = 11;

    // ------------------------------
    // Timer block
    // ------------------------------
    localparam int NUM_TIMERS = 3;

    // Register offsets, timer index in adr[9:8]
    localparam logic [7:0] TM_LOAD  = 8'h00;
    localparam logic [7:0] TM_VALUE = 8'h04;
    localparam logic [7:0] TM_CTRL  = 8'h08;
    localparam logic [7:0] TM_CLR   = 8'h0C;

    // ------------------------------
    // Interrupt controller
    // ------------------------------
    localparam logic [7:0] IC_IRQ_STATUS  = 8'h00;
    localparam logic [7:0] IC_RAW_STATUS  = 8'h04;
    localparam logic [7:0] IC_IRQ_EN_SET  = 8'h08;
    localparam logic [7:0] IC_IRQ_EN_CLR  = 8'h0C;
    localparam logic [7:0] IC_FIRQ_STATUS = 8'h10;
    localparam logic [7:0] IC_FIRQ_EN_SET = 8'h18;
    localparam logic [7:0] IC_FIRQ_EN_CLR = 8'h1C;

    // Source bit positions
    localparam int INT_UART   = 0;
    localparam int INT_ETH    = 1;
    localparam int INT_TIMER0 = 2;
    localparam int NUM_INT    = 5;

endpackage

`default_nettype wire

/* src/wb_interconnect.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_interconnect (
    input  logic                            i_clk,
    input  logic                            i_rst_n,

    // Master 0, Ethernet DMA
    input  logic [amber_pkg::WB_AWIDTH-1:0] i_m0_adr,
    input  logic [amber_pkg::WB_SWIDTH-1:0] i_m0_sel,
    input  logic                            i_m0_we,
    input  logic [amber_pkg::WB_DWIDTH-1:0] i_m0_wdat,
    input  logic                            i_m0_cyc,
    input  logic                            i_m0_stb,
    output logic [amber_pkg::WB_DWIDTH-1:0] o_m0_rdat,
    output logic                            o_m0_ack,
    output logic                            o_m0_err,

    // Master 1, processor
    input  logic [amber_pkg::WB_AWIDTH-1:0] i_m1_adr,
    input  logic [amber_pkg::WB_SWIDTH-1:0] i_m1_sel,
    input  logic                            i_m1_we,
    input  logic [amber_pkg::WB_DWIDTH-1:0] i_m1_wdat,
    input  logic                            i_m1_cyc,
    input  logic                            i_m1_stb,
    output logic [amber_pkg::WB_DWIDTH-1:0] o_m1_rdat,
    output logic                            o_m1_ack,
    output logic                            o_m1_err,

    // Shared slave request
    output logic [amber_pkg::WB_AWIDTH-1:0] o_s_adr,
    output logic [amber_pkg::WB_SWIDTH-1:0] o_s_sel,
    output logic                            o_s_we,
    output logic [amber_pkg::WB_DWIDTH-1:0] o_s_wdat,

    // Per-slave strobes and responses
    output logic                            o_mem_stb,
    output logic                            o_tm_stb,
    output logic                            o_ic_stb,
    input  logic [amber_pkg::WB_DWIDTH-1:0] i_mem_rdat,
    input  logic                            i_mem_ack,
    input  logic [amber_pkg::WB_DWIDTH-1:0] i_tm_rdat,
    input  logic                            i_tm_ack,
    input  logic [amber_pkg::WB_DWIDTH-1:0] i_ic_rdat,
    input  logic                            i_ic_ack
);

    logic                                                       owner_m1;
    logic                                                       gnt_m1;
    logic                                                       stb;
    logic [amber_pkg::SLAVE_SEL_HI-amber_pkg::SLAVE_SEL_LO:0]   region;
    logic                                                       hit_mem;
    logic                                                       hit_tm;
    logic                                                       hit_ic;
    logic                                                       err_q;
    logic [amber_pkg::WB_DWIDTH-1:0]                            s_rdat;
    logic                                                       s_ack;

    // ------------------------------
    // Arbitration
    // ------------------------------

    // Owner keeps the bus while its cyc stays high, otherwise master 0 wins
    assign gnt_m1 = owner_m1 ? i_m1_cyc : (~i_m0_cyc & i_m1_cyc);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            owner_m1 <= 1'b0;
        end else begin
            owner_m1 <= gnt_m1;
        end
    end

    assign stb      = gnt_m1 ? (i_m1_cyc & i_m1_stb) : (i_m0_cyc & i_m0_stb);
    assign o_s_adr  = gnt_m1 ? i_m1_adr  : i_m0_adr;
    assign o_s_sel  = gnt_m1 ? i_m1_sel  : i_m0_sel;
    assign o_s_we   = gnt_m1 ? i_m1_we   : i_m0_we;
    assign o_s_wdat = gnt_m1 ? i_m1_wdat : i_m0_wdat;

    // ------------------------------
    // Address decode
    // ------------------------------
    assign region  = o_s_adr[amber_pkg::SLAVE_SEL_HI:amber_pkg::SLAVE_SEL_LO];
    assign hit_mem = (region == amber_pkg::BOOT_MEM_BASE);
    assign hit_tm  = (region == amber_pkg::TIMER_BASE);
    assign hit_ic  = (region == amber_pkg::IC_BASE);

    assign o_mem_stb = stb & hit_mem;
    assign o_tm_stb  = stb & hit_tm;
    assign o_ic_stb  = stb & hit_ic;

    // Unmapped region, one err pulse per held strobe
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= stb & ~(hit_mem | hit_tm | hit_ic) & ~err_q;
        end
    end

    // Response steering
    always_comb begin
        s_rdat = '0;
        s_ack  = 1'b0;
        if (hit_mem) begin
            s_rdat = i_mem_rdat;
            s_ack  = i_mem_ack;
        end else if (hit_tm) begin
            s_rdat = i_tm_rdat;
            s_ack  = i_tm_ack;
        end else if (hit_ic) begin
            s_rdat = i_ic_rdat;
            s_ack  = i_ic_ack;
        end
    end

    assign o_m0_rdat = gnt_m1 ? '0 : s_rdat;
    assign o_m0_ack  = ~gnt_m1 & s_ack;
    assign o_m0_err  = ~gnt_m1 & err_q;
    assign o_m1_rdat = gnt_m1 ? s_rdat : '0;
    assign o_m1_ack  = gnt_m1 & s_ack;
    assign o_m1_err  = gnt_m1 & err_q;

endmodule

`default_nettype wire

/* src/boot_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_mem (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic [amber_pkg::WB_AWIDTH-1:0] i_adr,
    input  logic [amber_pkg::WB_SWIDTH-1:0] i_sel,
    input  logic                            i_we,
    input  logic [amber_pkg::WB_DWIDTH-1:0] i_wdat,
    input  logic                            i_stb,
    output logic [amber_pkg::WB_DWIDTH-1:0] o_rdat,
    output logic                            o_ack
);

    logic [amber_pkg::WB_DWIDTH-1:0]        mem [amber_pkg::BOOT_MEM_WORDS];
    logic [amber_pkg::BOOT_MEM_AWIDTH-1:0]  word_adr;
    logic                                   access;

    assign word_adr = i_adr[amber_pkg::BOOT_MEM_AWIDTH+1:2];

    // New request only while no ack is out
    assign access = i_stb & ~o_ack;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= access;
        end
    end

    // Byte lane writes
    always_ff @(posedge i_clk) begin
        if (access && i_we) begin
            for (int b = 0; b < amber_pkg::WB_SWIDTH; b++) begin
                if (i_sel[b]) begin
                    mem[word_adr][b*8 +: 8] <= i_wdat[b*8 +: 8];
                end
            end
        end
    end

    // Read word presented together with ack
    always_ff @(posedge i_clk) begin
        if (access) begin
            o_rdat <= mem[word_adr];
        end
    end

endmodule

`default_nettype wire

/* src/timer_module.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_module (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic [amber_pkg::WB_AWIDTH-1:0]   i_adr,
    input  logic                              i_we,
    input  logic [amber_pkg::WB_DWIDTH-1:0]   i_wdat,
    input  logic                              i_stb,
    output logic [amber_pkg::WB_DWIDTH-1:0]   o_rdat,
    output logic                              o_ack,
    output logic [amber_pkg::NUM_TIMERS-1:0]  o_timer_int
);

    logic [amber_pkg::WB_DWIDTH-1:0]    load_q  [amber_pkg::NUM_TIMERS];
    logic [amber_pkg::WB_DWIDTH-1:0]    value_q [amber_pkg::NUM_TIMERS];
    logic [amber_pkg::NUM_TIMERS-1:0]   enable_q;
    logic [1:0]                         tidx;
    logic                               access;
    logic [amber_pkg::WB_DWIDTH-1:0]    rd_word;

    assign tidx   = i_adr[9:8];
    assign access = i_stb & ~o_ack;

    // ------------------------------
    // Counters
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int t = 0; t < amber_pkg::NUM_TIMERS; t++) begin
                load_q[t]  <= '0;
                value_q[t] <= '0;
            end
            enable_q    <= '0;
            o_timer_int <= '0;
        end else begin
            for (int t = 0; t < amber_pkg::NUM_TIMERS; t++) begin
                // Count down, reload and flag at zero
                if (enable_q[t]) begin
                    if (value_q[t] == '0) begin
                        value_q[t]     <= load_q[t];
                        o_timer_int[t] <= 1'b1;
                    end else begin
                        value_q[t] <= value_q[t] - 1'b1;
                    end
                end
                // Bus writes take precedence
                if (access && i_we && tidx == 2'(t)) begin
                    case (i_adr[7:0])
                        amber_pkg::TM_LOAD: begin
                            load_q[t]  <= i_wdat;
                            value_q[t] <= i_wdat;
                        end
                        amber_pkg::TM_CTRL: enable_q[t]    <= i_wdat[0];
                        amber_pkg::TM_CLR:  o_timer_int[t] <= 1'b0;
                        default: ;
                    endcase
                end
            end
        end
    end

    // ------------------------------
    // Bus response
    // ------------------------------
    always_comb begin
        rd_word = '0;
        if (tidx < 2'(amber_pkg::NUM_TIMERS)) begin
            case (i_adr[7:0])
                amber_pkg::TM_LOAD:  rd_word = load_q[tidx];
                amber_pkg::TM_VALUE: rd_word = value_q[tidx];
                amber_pkg::TM_CTRL:  rd_word = {{(amber_pkg::WB_DWIDTH-1){1'b0}}, enable_q[tidx]};
                default:             rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= access;
        end
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            o_rdat <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* src/interrupt_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module interrupt_controller (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic [amber_pkg::WB_AWIDTH-1:0]   i_adr,
    input  logic                              i_we,
    input  logic [amber_pkg::WB_DWIDTH-1:0]   i_wdat,
    input  logic                              i_stb,
    input  logic                              i_uart_int,
    input  logic                              i_eth_int,
    input  logic [amber_pkg::NUM_TIMERS-1:0]  i_timer_int,
    output logic [amber_pkg::WB_DWIDTH-1:0]   o_rdat,
    output logic                              o_ack,
    output logic                              o_irq,
    output logic                              o_firq
);

    logic [amber_pkg::NUM_INT-1:0]      raw;
    logic [amber_pkg::NUM_INT-1:0]      irq_en;
    logic [amber_pkg::NUM_INT-1:0]      firq_en;
    logic [amber_pkg::NUM_INT-1:0]      wr_mask;
    logic                               access;
    logic [amber_pkg::WB_DWIDTH-1:0]    rd_word;

    // Level sources
    assign raw[amber_pkg::INT_UART] = i_uart_int;
    assign raw[amber_pkg::INT_ETH]  = i_eth_int;
    assign raw[amber_pkg::INT_TIMER0 +: amber_pkg::NUM_TIMERS] = i_timer_int;

    assign access  = i_stb & ~o_ack;
    assign wr_mask = i_wdat[amber_pkg::NUM_INT-1:0];

    // ------------------------------
    // Enable masks and outputs
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            irq_en  <= '0;
            firq_en <= '0;
            o_irq   <= 1'b0;
            o_firq  <= 1'b0;
            o_ack   <= 1'b0;
        end else begin
            o_ack  <= access;
            o_irq  <= |(raw & irq_en);
            o_firq <= |(raw & firq_en);
            // Set and clear by writing ones
            if (access && i_we) begin
                case (i_adr[7:0])
                    amber_pkg::IC_IRQ_EN_SET:  irq_en  <= irq_en | wr_mask;
                    amber_pkg::IC_IRQ_EN_CLR:  irq_en  <= irq_en & ~wr_mask;
                    amber_pkg::IC_FIRQ_EN_SET: firq_en <= firq_en | wr_mask;
                    amber_pkg::IC_FIRQ_EN_CLR: firq_en <= firq_en & ~wr_mask;
                    default: ;
                endcase
            end
        end
    end

    // Status readback
    always_comb begin
        rd_word = '0;
        case (i_adr[7:0])
            amber_pkg::IC_IRQ_STATUS:  rd_word[amber_pkg::NUM_INT-1:0] = raw & irq_en;
            amber_pkg::IC_RAW_STATUS:  rd_word[amber_pkg::NUM_INT-1:0] = raw;
            amber_pkg::IC_FIRQ_STATUS: rd_word[amber_pkg::NUM_INT-1:0] = raw & firq_en;
            default:                   rd_word = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            o_rdat <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* src/system.sv */
`timescale 1ns/1ps
`default_nettype none

module system (
    input  logic                            i_clk,
    input  logic                            i_rst_n,

    // Ethernet DMA master port
    input  logic [amber_pkg::WB_AWIDTH-1:0] i_m0_adr,
    input  logic [amber_pkg::WB_SWIDTH-1:0] i_m0_sel,
    input  logic                            i_m0_we,
    input  logic [amber_pkg::WB_DWIDTH-1:0] i_m0_wdat,
    input  logic                            i_m0_cyc,
    input  logic                            i_m0_stb,
    output logic [amber_pkg::WB_DWIDTH-1:0] o_m0_rdat,
    output logic                            o_m0_ack,
    output logic                            o_m0_err,

    // Processor master port
    input  logic [amber_pkg::WB_AWIDTH-1:0] i_m1_adr,
    input  logic [amber_pkg::WB_SWIDTH-1:0] i_m1_sel,
    input  logic                            i_m1_we,
    input  logic [amber_pkg::WB_DWIDTH-1:0] i_m1_wdat,
    input  logic                            i_m1_cyc,
    input  logic                            i_m1_stb,
    output logic [amber_pkg::WB_DWIDTH-1:0] o_m1_rdat,
    output logic                            o_m1_ack,
    output logic                            o_m1_err,

    // Interrupts
    input  logic                            i_uart_int,
    input  logic                            i_eth_int,
    output logic                            o_irq,
    output logic                            o_firq
);

    logic [amber_pkg::WB_AWIDTH-1:0]    s_adr;
    logic [amber_pkg::WB_SWIDTH-1:0]    s_sel;
    logic                               s_we;
    logic [amber_pkg::WB_DWIDTH-1:0]    s_wdat;
    logic                               mem_stb;
    logic                               tm_stb;
    logic                               ic_stb;
    logic [amber_pkg::WB_DWIDTH-1:0]    mem_rdat;
    logic [amber_pkg::WB_DWIDTH-1:0]    tm_rdat;
    logic [amber_pkg::WB_DWIDTH-1:0]    ic_rdat;
    logic                               mem_ack;
    logic                               tm_ack;
    logic                               ic_ack;
    logic [amber_pkg::NUM_TIMERS-1:0]   timer_int;

    // ------------------------------
    // Bus fabric
    // ------------------------------
    wb_interconnect u_wb_interconnect (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_m0_adr   (i_m0_adr),
        .i_m0_sel   (i_m0_sel),
        .i_m0_we    (i_m0_we),
        .i_m0_wdat  (i_m0_wdat),
        .i_m0_cyc   (i_m0_cyc),
        .i_m0_stb   (i_m0_stb),
        .o_m0_rdat  (o_m0_rdat),
        .o_m0_ack   (o_m0_ack),
        .o_m0_err   (o_m0_err),
        .i_m1_adr   (i_m1_adr),
        .i_m1_sel   (i_m1_sel),
        .i_m1_we    (i_m1_we),
        .i_m1_wdat  (i_m1_wdat),
        .i_m1_cyc   (i_m1_cyc),
        .i_m1_stb   (i_m1_stb),
        .o_m1_rdat  (o_m1_rdat),
        .o_m1_ack   (o_m1_ack),
        .o_m1_err   (o_m1_err),
        .o_s_adr    (s_adr),
        .o_s_sel    (s_sel),
        .o_s_we     (s_we),
        .o_s_wdat   (s_wdat),
        .o_mem_stb  (mem_stb),
        .o_tm_stb   (tm_stb),
        .o_ic_stb   (ic_stb),
        .i_mem_rdat (mem_rdat),
        .i_mem_ack  (mem_ack),
        .i_tm_rdat  (tm_rdat),
        .i_tm_ack   (tm_ack),
        .i_ic_rdat  (ic_rdat),
        .i_ic_ack   (ic_ack)
    );

    // ------------------------------
    // Slaves
    // ------------------------------
    boot_mem u_boot_mem (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_adr   (s_adr),
        .i_sel   (s_sel),
        .i_we    (s_we),
        .i_wdat  (s_wdat),
        .i_stb   (mem_stb),
        .o_rdat  (mem_rdat),
        .o_ack   (mem_ack)
    );

    timer_module u_timer_module (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_adr       (s_adr),
        .i_we        (s_we),
        .i_wdat      (s_wdat),
        .i_stb       (tm_stb),
        .o_rdat      (tm_rdat),
        .o_ack       (tm_ack),
        .o_timer_int (timer_int)
    );

    interrupt_controller u_interrupt_controller (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_adr       (s_adr),
        .i_we        (s_we),
        .i_wdat      (s_wdat),
        .i_stb       (ic_stb),
        .i_uart_int  (i_uart_int),
        .i_eth_int   (i_eth_int),
        .i_timer_int (timer_int),
        .o_rdat      (ic_rdat),
        .o_ack       (ic_ack),
        .o_irq       (o_irq),
        .o_firq      (o_firq)
    );

endmodule

`default_nettype wire

/* sim/tb_system.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_system;

    localparam int MAX_CYCLES = 2000;
    localparam int ACK_WAIT   = 16;
    localparam int NUM_WORDS  = 16;

    logic        clk;
    logic        rst_n;
    logic [31:0] m0_adr;
    logic [3:0]  m0_sel;
    logic        m0_we;
    logic [31:0] m0_wdat;
    logic        m0_cyc;
    logic        m0_stb;
    logic [31:0] m0_rdat;
    logic        m0_ack;
    logic        m0_err;
    logic [31:0] m1_adr;
    logic [3:0]  m1_sel;
    logic        m1_we;
    logic [31:0] m1_wdat;
    logic        m1_cyc;
    logic        m1_stb;
    logic [31:0] m1_rdat;
    logic        m1_ack;
    logic        m1_err;
    logic        uart_int;
    logic        eth_int;
    logic        irq;
    logic        firq;

    int          cycle_cnt = 0;
    logic [31:0] word_adr [NUM_WORDS];
    logic [31:0] exp_word [NUM_WORDS];

    system i_dut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_m0_adr   (m0_adr),
        .i_m0_sel   (m0_sel),
        .i_m0_we    (m0_we),
        .i_m0_wdat  (m0_wdat),
        .i_m0_cyc   (m0_cyc),
        .i_m0_stb   (m0_stb),
        .o_m0_rdat  (m0_rdat),
        .o_m0_ack   (m0_ack),
        .o_m0_err   (m0_err),
        .i_m1_adr   (m1_adr),
        .i_m1_sel   (m1_sel),
        .i_m1_we    (m1_we),
        .i_m1_wdat  (m1_wdat),
        .i_m1_cyc   (m1_cyc),
        .i_m1_stb   (m1_stb),
        .o_m1_rdat  (m1_rdat),
        .o_m1_ack   (m1_ack),
        .o_m1_err   (m1_err),
        .i_uart_int (uart_int),
        .i_eth_int  (eth_int),
        .o_irq      (irq),
        .o_firq     (firq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        report_failure($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end

    // ------------------------------
    // Reporting and bus helpers
    // ------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Error: %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] tm_addr(input logic [1:0] idx, input logic [7:0] off);
        return {amber_pkg::TIMER_BASE, 14'h0, idx, off};
    endfunction

    function automatic logic [31:0] ic_addr(input logic [7:0] off);
        return {amber_pkg::IC_BASE, 16'h0, off};
    endfunction

    // Reference byte-lane merge for sel writes
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] sel);
        logic [31:0] res;
        for (int b = 0; b < 4; b++) begin
            res[b*8 +: 8] = sel[b] ? new_word[b*8 +: 8] : old_word[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic drive_req(input int m, input logic [31:0] adr, input logic [3:0] sel,
                             input logic we, input logic [31:0] wdat);
        if (m == 0) begin
            m0_adr  = adr;
            m0_sel  = sel;
            m0_we   = we;
            m0_wdat = wdat;
            m0_cyc  = 1'b1;
            m0_stb  = 1'b1;
        end else begin
            m1_adr  = adr;
            m1_sel  = sel;
            m1_we   = we;
            m1_wdat = wdat;
            m1_cyc  = 1'b1;
            m1_stb  = 1'b1;
        end
    endtask

    task automatic drive_idle(input int m);
        if (m == 0) begin
            m0_cyc = 1'b0;
            m0_stb = 1'b0;
            m0_we  = 1'b0;
        end else begin
            m1_cyc = 1'b0;
            m1_stb = 1'b0;
            m1_we  = 1'b0;
        end
    endtask

    // One access that waits for ack or err and counts cycles after the strobe edge
    task automatic bus_access(input int m, input logic [31:0] adr, input logic [3:0] sel,
                              input logic we, input logic [31:0] wdat,
                              output logic [31:0] rdat, output logic ack,
                              output logic err, output int lat);
        @(negedge clk);
        drive_req(m, adr, sel, we, wdat);
        lat = 0;
        ack = 1'b0;
        err = 1'b0;
        while (!ack && !err && lat < ACK_WAIT) begin
            @(negedge clk);
            lat++;
            ack = (m == 0) ? m0_ack : m1_ack;
            err = (m == 0) ? m0_err : m1_err;
        end
        rdat = (m == 0) ? m0_rdat : m1_rdat;
        drive_idle(m);
        if (!ack && !err) begin
            report_failure($sformatf("No ack or err for master %0d access to 0x%08h", m, adr));
        end
    endtask

    task automatic check_done(input int m, input logic ack, input logic err, input int lat);
        check_eq($sformatf("o_m%0d_ack", m), 32'(ack), 32'h1);
        check_eq($sformatf("o_m%0d_err", m), 32'(err), 32'h0);
        check_eq($sformatf("o_m%0d_ack latency", m), 32'(lat), 32'd1);
    endtask

    task automatic wb_write(input int m, input logic [31:0] adr, input logic [3:0] sel,
                            input logic [31:0] wdat);
        logic [31:0] rdat;
        logic        ack;
        logic        err;
        int          lat;
        bus_access(m, adr, sel, 1'b1, wdat, rdat, ack, err, lat);
        check_done(m, ack, err, lat);
    endtask

    task automatic wb_read(input int m, input logic [31:0] adr, output logic [31:0] rdat);
        logic ack;
        logic err;
        int   lat;
        bus_access(m, adr, 4'hf, 1'b0, 32'h0, rdat, ack, err, lat);
        check_done(m, ack, err, lat);
    endtask

    task automatic set_int_pins(input logic uart, input logic eth);
        @(negedge clk);
        uart_int = uart;
        eth_int  = eth;
    endtask

    // Polls o_irq (0) or o_firq (1) until it reaches the level
    task automatic wait_output(input int which, input logic level);
        string name;
        int    n;
        name = (which == 0) ? "o_irq" : "o_firq";
        n = 0;
        while (((which == 0) ? irq : firq) !== level && n < 8) begin
            @(negedge clk);
            n++;
        end
        check_eq(name, 32'((which == 0) ? irq : firq), 32'(level));
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_memory();
        logic [31:0] rdat;
        logic [31:0] data;
        logic [3:0]  sel;
        int          i;
        for (i = 0; i < NUM_WORDS; i++) begin
            word_adr[i] = 32'((i * 131) % amber_pkg::BOOT_MEM_WORDS) << 2;
            exp_word[i] = $urandom();
            wb_write(1, word_adr[i], 4'hf, exp_word[i]);
        end
        for (i = 0; i < NUM_WORDS; i++) begin
            wb_read(1, word_adr[i], rdat);
            check_eq("o_m1_rdat", rdat, exp_word[i]);
        end
        // Single byte lanes
        for (i = 0; i < 8; i++) begin
            sel  = 4'b0001 << (i % 4);
            data = $urandom();
            wb_write(1, word_adr[i], sel, data);
            exp_word[i] = merge_bytes(exp_word[i], data, sel);
        end
        for (i = 0; i < NUM_WORDS; i++) begin
            wb_read(1, word_adr[i], rdat);
            check_eq("o_m1_rdat", rdat, exp_word[i]);
        end
    endtask

    task automatic test_bus_error();
        logic [31:0] rdat;
        logic        ack;
        logic        err;
        int          lat;
        bus_access(1, 32'h2000_0010, 4'hf, 1'b0, 32'h0, rdat, ack, err, lat);
        check_eq("o_m1_err", 32'(err), 32'h1);
        check_eq("o_m1_ack", 32'(ack), 32'h0);
        check_eq("o_m1_err latency", 32'(lat), 32'd1);
        bus_access(0, 32'h2000_0100, 4'hf, 1'b1, 32'h1234_5678, rdat, ack, err, lat);
        check_eq("o_m0_err", 32'(err), 32'h1);
        check_eq("o_m0_ack", 32'(ack), 32'h0);
        check_eq("o_m0_err latency", 32'(lat), 32'd1);
        wb_read(1, word_adr[0], rdat);
        check_eq("o_m1_rdat", rdat, exp_word[0]);
    endtask

    task automatic test_arbitration();
        int lat;
        @(negedge clk);
        drive_req(0, word_adr[2], 4'hf, 1'b0, 32'h0);
        drive_req(1, word_adr[3], 4'hf, 1'b0, 32'h0);
        @(negedge clk);
        check_eq("o_m0_ack", 32'(m0_ack), 32'h1);
        check_eq("o_m1_ack", 32'(m1_ack), 32'h0);
        check_eq("o_m0_rdat", m0_rdat, exp_word[2]);
        // Master 0 keeps cyc with stb low so master 1 must wait
        m0_stb = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_eq("o_m1_ack", 32'(m1_ack), 32'h0);
            check_eq("o_m0_ack", 32'(m0_ack), 32'h0);
        end
        m0_cyc = 1'b0;
        lat = 0;
        while (!m1_ack && lat < ACK_WAIT) begin
            @(negedge clk);
            lat++;
        end
        check_eq("o_m1_ack", 32'(m1_ack), 32'h1);
        check_eq("o_m1_ack latency", 32'(lat), 32'd1);
        check_eq("o_m1_rdat", m1_rdat, exp_word[3]);
        // Master 1 owns the bus while it keeps cyc so master 0 must wait
        m1_stb = 1'b0;
        drive_req(0, word_adr[4], 4'hf, 1'b0, 32'h0);
        repeat (3) begin
            @(negedge clk);
            check_eq("o_m0_ack", 32'(m0_ack), 32'h0);
            check_eq("o_m1_ack", 32'(m1_ack), 32'h0);
        end
        m1_cyc = 1'b0;
        lat = 0;
        while (!m0_ack && lat < ACK_WAIT) begin
            @(negedge clk);
            lat++;
        end
        check_eq("o_m0_ack", 32'(m0_ack), 32'h1);
        check_eq("o_m0_ack latency", 32'(lat), 32'd1);
        check_eq("o_m0_rdat", m0_rdat, exp_word[4]);
        drive_idle(0);
        drive_idle(1);
    endtask

    task automatic test_timer();
        logic [31:0] rdat;
        int          start;
        wb_write(1, tm_addr(2'd1, amber_pkg::TM_LOAD), 4'hf, 32'd10);
        wb_read(1, tm_addr(2'd1, amber_pkg::TM_LOAD), rdat);
        check_eq("timer 1 load", rdat, 32'd10);
        wb_read(1, ic_addr(amber_pkg::IC_RAW_STATUS), rdat);
        check_eq("raw status", rdat, 32'h0);
        start = cycle_cnt;
        wb_write(1, tm_addr(2'd1, amber_pkg::TM_CTRL), 4'hf, 32'h1);
        rdat = '0;
        while (!rdat[amber_pkg::INT_TIMER0 + 1] && cycle_cnt - start < 40) begin
            wb_read(1, ic_addr(amber_pkg::IC_RAW_STATUS), rdat);
            check_eq("raw status timers 0 and 2", rdat & 32'h14, 32'h0);
        end
        // Timer 1 sits at bit 3
        check_eq("raw status", rdat, 32'h8);
        wb_write(1, tm_addr(2'd1, amber_pkg::TM_CTRL), 4'hf, 32'h0);
        wb_write(1, tm_addr(2'd1, amber_pkg::TM_CLR), 4'hf, 32'h0);
        wb_read(1, ic_addr(amber_pkg::IC_RAW_STATUS), rdat);
        check_eq("raw status", rdat, 32'h0);
    endtask

    task automatic test_interrupts();
        logic [31:0] rdat;
        set_int_pins(1'b1, 1'b0);
        wb_write(1, ic_addr(amber_pkg::IC_IRQ_EN_SET), 4'hf, 32'h1);
        wait_output(0, 1'b1);
        wb_read(1, ic_addr(amber_pkg::IC_IRQ_STATUS), rdat);
        check_eq("irq status", rdat, 32'h1);
        wb_write(1, ic_addr(amber_pkg::IC_IRQ_EN_CLR), 4'hf, 32'h1);
        wait_output(0, 1'b0);
        // Ethernet source on firq
        set_int_pins(1'b1, 1'b1);
        wb_write(1, ic_addr(amber_pkg::IC_FIRQ_EN_SET), 4'hf, 32'h2);
        wait_output(1, 1'b1);
        check_eq("o_irq", 32'(irq), 32'h0);
        set_int_pins(1'b1, 1'b0);
        wait_output(1, 1'b0);
        set_int_pins(1'b1, 1'b1);
        wait_output(1, 1'b1);
        wb_read(1, ic_addr(amber_pkg::IC_FIRQ_STATUS), rdat);
        check_eq("firq status", rdat, 32'h2);
        wb_read(1, ic_addr(amber_pkg::IC_RAW_STATUS), rdat);
        check_eq("raw status", rdat, 32'h3);
        wb_read(1, ic_addr(amber_pkg::IC_IRQ_STATUS), rdat);
        check_eq("irq status", rdat, 32'h0);
        wb_write(1, ic_addr(amber_pkg::IC_IRQ_EN_SET), 4'hf, 32'h2);
        wb_read(1, ic_addr(amber_pkg::IC_IRQ_STATUS), rdat);
        check_eq("irq status", rdat, 32'h2);
        wait_output(0, 1'b1);
        set_int_pins(1'b0, 1'b0);
        wait_output(0, 1'b0);
        wait_output(1, 1'b0);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        void'($urandom(32'ha55606f8));
        rst_n    = 1'b0;
        m0_adr   = '0;
        m0_sel   = '0;
        m0_we    = 1'b0;
        m0_wdat  = '0;
        m0_cyc   = 1'b0;
        m0_stb   = 1'b0;
        m1_adr   = '0;
        m1_sel   = '0;
        m1_we    = 1'b0;
        m1_wdat  = '0;
        m1_cyc   = 1'b0;
        m1_stb   = 1'b0;
        uart_int = 1'b0;
        eth_int  = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_eq("o_m0_ack", 32'(m0_ack), 32'h0);
        check_eq("o_m1_ack", 32'(m1_ack), 32'h0);
        check_eq("o_m0_err", 32'(m0_err), 32'h0);
        check_eq("o_m1_err", 32'(m1_err), 32'h0);
        check_eq("o_irq", 32'(irq), 32'h0);
        check_eq("o_firq", 32'(firq), 32'h0);
        test_memory();
        test_bus_error();
        test_arbitration();
        test_timer();
        test_interrupts();
        @(negedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
src/amber_pkg.sv
src/wb_interconnect.sv
src/boot_mem.sv
src/timer_module.sv
src/interrupt_controller.sv
src/system.sv
sim/tb_system.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run, pass only if the pass message is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_system -f project.f \
    && { out=$(./obj_dir/Vtb_system); echo "$out"; echo "$out" | grep -q "^NO ERRORS$"; } \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
